/* cache/dataArray.sv */
`include "cache_defs.svh"

module dataArray import cachePkg::*; (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic [31:0]      lookupAddr,
	input  logic [`WAYS-1:0] hit,
	input  lineWrT           lineWr,
	output logic [31:0]      rdWord
);

	logic [31:0]          words [`WAYS][`SETS*`LINE_WORDS];
	logic [`INDEX_W+1:0]  rdAddr;
	logic [`INDEX_W+1:0]  wrAddr;
	logic [3:0]           byteEn;

	assign rdAddr = {lookupAddr[`INDEX_RANGE], lookupAddr[`WORD_SEL]};
	assign wrAddr = {lineWr.addr[`INDEX_RANGE], lineWr.addr[`WORD_SEL]};

	// nothing is written while reset is held
	always_comb begin
		byteEn = 4'h0;
		if (RST_N) begin
			case (lineWr.op)
				opFill:  byteEn = 4'hF;
				opWrite: byteEn = lineWr.be;
				default: byteEn = 4'h0;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		for (int w = 0; w < `WAYS; w++) begin
			for (int b = 0; b < 4; b++) begin
				if (lineWr.way[w] && byteEn[b]) begin
					words[w][wrAddr][b*8 +: 8] <= lineWr.data[b*8 +: 8];
				end
			end
		end
	end

	// hit is one-hot, so OR of the selected ways
	always_comb begin
		rdWord = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (hit[w]) begin
				rdWord = rdWord | words[w][rdAddr];
			end
		end
	end

endmodule

/* cache/lruArray.sv */
`include "cache_defs.svh"

module lruArray import cachePkg::*; (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic [31:0]      lookupAddr,
	input  lruTouchT         touch,
	input  logic             flashClear,
	output logic [`WAYS-1:0] victim
);

	logic [`LRU_W-1:0]   hist [`SETS];
	logic [`INDEX_W-1:0] rdIdx;

	assign rdIdx = lookupAddr[`INDEX_RANGE];

	// cleared history picks way 3 first
	assign victim = lruVictim(hist[rdIdx]);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < `SETS; s++) begin
				hist[s] <= '0;
			end
		end
		else if (flashClear) begin
			for (int s = 0; s < `SETS; s++) begin
				hist[s] <= '0;
			end
		end
		else if (touch.en) begin
			hist[touch.setIdx] <= lruUpdate(touch.way, hist[touch.setIdx]);
		end
	end

endmodule

/* cache/tagArray.sv */
`include "cache_defs.svh"

module tagArray import cachePkg::*; (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic [31:0]      lookupAddr,
	input  lineWrT           lineWr,
	input  logic             flashClear,
	output logic [`WAYS-1:0] hit
);

	logic [`TAG_W-1:0]   tags [`SETS][`WAYS];
	logic [`WAYS-1:0]    valid [`SETS];
	logic [`INDEX_W-1:0] rdIdx;
	logic [`INDEX_W-1:0] wrIdx;
	logic                fill;

	assign rdIdx = lookupAddr[`INDEX_RANGE];
	assign wrIdx = lineWr.addr[`INDEX_RANGE];
	assign fill = lineWr.op == opFill;

	// all four ways compared at once
	always_comb begin
		for (int w = 0; w < `WAYS; w++) begin
			hit[w] = valid[rdIdx][w] && (tags[rdIdx][w] == lookupAddr[`TAG_RANGE]);
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < `SETS; s++) begin
				valid[s] <= '0;
			end
		end
		else if (flashClear) begin
			for (int s = 0; s < `SETS; s++) begin
				valid[s] <= '0;
			end
		end
		else if (fill) begin
			valid[wrIdx] <= valid[wrIdx] | lineWr.way;
		end
	end

	// tag rewritten on every fill beat, same value each time
	always_ff @(posedge CLK) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (fill && lineWr.way[w]) begin
				tags[wrIdx][w] <= lineWr.addr[`TAG_RANGE];
			end
		end
	end

endmodule

/* common/cachePkg.sv */
`include "cache_defs.svh"

package cachePkg;

	typedef struct packed {
		logic        req;
		logic        wr;
		logic [3:0]  be;
		logic [31:0] addr;
		logic [31:0] wdata;
	} cpuReqT;

	typedef struct packed {
		logic        req;
		logic        we;
		logic        lock;
		logic [3:0]  be;
		logic [31:0] addr;
		logic [31:0] wdata;
	} memReqT;

	// unused bits always read as zero
	typedef struct packed {
		logic [2:0] rsv7;
		logic       cp;
		logic [2:0] rsv3;
		logic       ce;
	} ccrT;

	typedef enum logic [1:0] {
		opNone,
		opFill,
		opWrite
	} arrayOpE;

	typedef struct packed {
		arrayOpE          op;
		logic [`WAYS-1:0] way;
		logic [28:2]      addr;
		logic [3:0]       be;
		logic [31:0]      data;
	} lineWrT;

	typedef struct packed {
		logic                en;
		logic [`INDEX_W-1:0] setIdx;
		logic [`WAYS-1:0]    way;
	} lruTouchT;

	typedef enum logic [2:0] {
		sIdle,
		sWrite,
		sRead,
		sFill,
		sDone
	} busStateE;

	// pairs 0-1, 0-2, 0-3, 1-2, 1-3, 2-3 from bit 5 down
	function automatic logic [`LRU_W-1:0] lruUpdate(input logic [`WAYS-1:0] way,
			input logic [`LRU_W-1:0] hist);
		logic [`LRU_W-1:0] next;
		next = hist;
		case (way)
			4'b0001: next = {1'b0, 1'b0, 1'b0, hist[2:0]};
			4'b0010: next = {1'b1, hist[4:3], 1'b0, 1'b0, hist[0]};
			4'b0100: next = {hist[5], 1'b1, hist[3], 1'b1, hist[1], 1'b0};
			4'b1000: next = {hist[5:4], 1'b1, hist[2], 1'b1, 1'b1};
			default: next = hist;
		endcase
		return next;
	endfunction

	// least recently used way, one-hot
	function automatic logic [`WAYS-1:0] lruVictim(input logic [`LRU_W-1:0] hist);
		if (hist[5] && hist[4] && hist[3])
			return 4'b0001;
		else if (!hist[5] && hist[2] && hist[1])
			return 4'b0010;
		else if (!hist[4] && !hist[2] && hist[0])
			return 4'b0100;
		else
			return 4'b1000;
	endfunction

endpackage

/* common/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define WAYS 4
`define SETS 64
`define LINE_WORDS 4

// address fields of a cached access
`define INDEX_W 6
`define INDEX_RANGE 9:4
`define TAG_W 19
`define TAG_RANGE 28:10
`define WORD_SEL 3:2

// pairwise LRU history per set
`define LRU_W 6

// cache control register, byte lane 1
`define CCR_ADDR 32'hFFFFFE92

`endif

/* files.f */
+incdir+common
common/cachePkg.sv
cache/tagArray.sv
cache/dataArray.sv
cache/lruArray.sv
rtl/ccrReg.sv
rtl/busControl.sv
rtl/cacheTop.sv
verif/clkGen.sv
verif/cache_chk.sv
verif/cacheTb.sv

/* rtl/busControl.sv */
`include "cache_defs.svh"

module busControl import cachePkg::*; (
	input  logic             CLK,
	input  logic             RST_N,
	input  cpuReqT           cpuReq,
	input  logic             ccrSel,
	input  ccrT              ccr,
	input  logic [`WAYS-1:0] hit,
	input  logic [`WAYS-1:0] victim,
	input  logic [31:0]      rdWord,
	input  logic [31:0]      IBUS_DI,
	input  logic             IBUS_WAIT,
	output lineWrT           lineWr,
	output lruTouchT         touch,
	output memReqT           memReq,
	output logic [31:0]      CBUS_DO,
	output logic             CBUS_BUSY
);

	busStateE         state;
	logic             memOn;
	logic             memWe;
	logic             memLock;
	logic             fromMem;
	logic [3:0]       memBe;
	logic [31:0]      memAddr;
	logic [31:0]      memWdata;
	logic [31:0]      rdData;
	logic [`WAYS-1:0] victimQ;
	logic [1:0]       wrapPos;

	logic cacheOn;
	logic anyHit;
	logic readHit;
	logic writeHit;
	logic accept;
	logic missAccept;
	logic beatDone;
	logic lastBeat;

	// region 000 with CE set goes through the arrays
	assign cacheOn = (cpuReq.addr[31:29] == 3'b000) && ccr.ce;
	assign anyHit = |hit;
	assign readHit = state == sIdle && cpuReq.req && !cpuReq.wr && !ccrSel && cacheOn && anyHit;
	assign writeHit = state == sIdle && cpuReq.req && cpuReq.wr && !ccrSel && cacheOn && anyHit;
	assign accept = state == sIdle && cpuReq.req && !ccrSel && !readHit;
	assign missAccept = accept && !cpuReq.wr && cacheOn;
	assign beatDone = memOn && !IBUS_WAIT;
	assign lastBeat = memAddr[`WORD_SEL] == wrapPos;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= sIdle;
			memOn <= 1'b0;
			memWe <= 1'b0;
			memLock <= 1'b0;
			fromMem <= 1'b0;
		end
		else begin
			case (state)
				sIdle: begin
					if (accept) begin
						memOn <= 1'b1;
						memWe <= cpuReq.wr;
						memLock <= missAccept;
						fromMem <= !cpuReq.wr && !cacheOn;
						if (cpuReq.wr)
							state <= sWrite;
						else if (missAccept)
							state <= sFill;
						else
							state <= sRead;
					end
				end
				sWrite, sRead: begin
					if (beatDone) begin
						memOn <= 1'b0;
						memWe <= 1'b0;
						state <= sDone;
					end
				end
				sFill: begin
					if (beatDone && lastBeat) begin
						memOn <= 1'b0;
						memLock <= 1'b0;
						state <= sDone;
					end
				end
				default: begin
					state <= sIdle;
				end
			endcase
		end
	end

	// burst starts one word past the requested one and wraps
	always_ff @(posedge CLK) begin
		if (accept) begin
			memBe <= missAccept ? 4'hF : cpuReq.be;
			memAddr <= missAccept ?
				{cpuReq.addr[31:4], cpuReq.addr[`WORD_SEL] + 2'd1, 2'b00} : cpuReq.addr;
			memWdata <= cpuReq.wdata;
			victimQ <= victim;
			wrapPos <= cpuReq.addr[`WORD_SEL];
		end
		else if (state == sFill && beatDone) begin
			memAddr[`WORD_SEL] <= memAddr[`WORD_SEL] + 2'd1;
		end
		if (state == sRead && beatDone) begin
			rdData <= IBUS_DI;
		end
	end

	always_comb begin
		lineWr.op = opNone;
		lineWr.way = hit;
		lineWr.addr = cpuReq.addr[28:2];
		lineWr.be = cpuReq.be;
		lineWr.data = cpuReq.wdata;
		if (writeHit) begin
			lineWr.op = opWrite;
		end
		else if (state == sFill && beatDone) begin
			lineWr.op = opFill;
			lineWr.way = victimQ;
			lineWr.addr = memAddr[28:2];
			lineWr.be = 4'hF;
			lineWr.data = IBUS_DI;
		end
	end

	always_comb begin
		touch.en = readHit || writeHit;
		touch.setIdx = cpuReq.addr[`INDEX_RANGE];
		touch.way = hit;
		if (state == sFill && beatDone) begin
			touch.en = 1'b1;
			touch.setIdx = memAddr[`INDEX_RANGE];
			touch.way = victimQ;
		end
	end

	assign memReq = '{req: memOn, we: memWe, lock: memLock, be: memBe,
		addr: memAddr, wdata: memWdata};

	// sDone after a fill reads the freshly written line
	always_comb begin
		if (ccrSel)
			CBUS_DO = {4{ccr}};
		else if (state == sDone && fromMem)
			CBUS_DO = rdData;
		else
			CBUS_DO = rdWord;
	end

	always_comb begin
		if (state == sIdle)
			CBUS_BUSY = cpuReq.req && !ccrSel && !readHit;
		else
			CBUS_BUSY = cpuReq.req && state != sDone;
	end

endmodule

/* rtl/cacheTop.sv */
`include "cache_defs.svh"

module cacheTop import cachePkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  cpuReqT      cpuReq,
	output logic [31:0] CBUS_DO,
	output logic        CBUS_BUSY,
	output memReqT      memReq,
	input  logic [31:0] IBUS_DI,
	input  logic        IBUS_WAIT
);

	lineWrT           lineWr;
	lruTouchT         touch;
	logic [`WAYS-1:0] hit;
	logic [`WAYS-1:0] victim;
	logic [31:0]      rdWord;
	logic             ccrSel;
	ccrT              ccr;

	tagArray u_tagArray (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.lookupAddr (cpuReq.addr),
		.lineWr     (lineWr),
		.flashClear (ccr.cp),
		.hit        (hit)
	);

	dataArray u_dataArray (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.lookupAddr (cpuReq.addr),
		.hit        (hit),
		.lineWr     (lineWr),
		.rdWord     (rdWord)
	);

	lruArray u_lruArray (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.lookupAddr (cpuReq.addr),
		.touch      (touch),
		.flashClear (ccr.cp),
		.victim     (victim)
	);

	busControl u_busControl (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cpuReq    (cpuReq),
		.ccrSel    (ccrSel),
		.ccr       (ccr),
		.hit       (hit),
		.victim    (victim),
		.rdWord    (rdWord),
		.IBUS_DI   (IBUS_DI),
		.IBUS_WAIT (IBUS_WAIT),
		.lineWr    (lineWr),
		.touch     (touch),
		.memReq    (memReq),
		.CBUS_DO   (CBUS_DO),
		.CBUS_BUSY (CBUS_BUSY)
	);

	ccrReg u_ccrReg (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.cpuReq (cpuReq),
		.ccrSel (ccrSel),
		.ccr    (ccr)
	);

endmodule

/* rtl/ccrReg.sv */
`include "cache_defs.svh"

module ccrReg import cachePkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  cpuReqT cpuReq,
	output logic   ccrSel,
	output ccrT    ccr
);

	// only CP and CE are writable
	localparam logic [7:0] WR_MASK = 8'h11;

	assign ccrSel = (cpuReq.addr == `CCR_ADDR) && cpuReq.be[1];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ccr <= '0;
		end
		else begin
			if (ccrSel && cpuReq.req && cpuReq.wr) begin
				ccr <= cpuReq.wdata[15:8] & WR_MASK;
			end
			// purge lasts a single cycle
			if (ccr.cp) begin
				ccr.cp <= 1'b0;
			end
		end
	end

endmodule

/* verif/cacheTb.sv */
`include "cache_defs.svh"

module cacheTb import cachePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 100;
	localparam logic [3:0] LANE1 = 4'b0010;

	typedef enum logic [1:0] {
		tRead,
		tWrite,
		tCcrRead,
		tCcrWrite
	} stepOpE;

	typedef struct packed {
		stepOpE      op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  be;
		logic [31:0] expWord;
		int          expCount;
	} stepT;

	logic        CLK;
	logic        RST_N;
	cpuReqT      cpuReq;
	logic [31:0] CBUS_DO;
	logic        CBUS_BUSY;
	memReqT      memReq;
	logic [31:0] IBUS_DI;
	logic        IBUS_WAIT;

	logic [31:0] mem [1024];
	logic [15:0] lfsr = 16'd14;
	int          waitLeft = 0;
	logic        beatActive = 1'b0;
	logic        completing = 1'b0;
	memReqT      beatReq;
	int          xferCount = 0;
	memReqT      xferLog [$];
	stepT        steps [$];

	clkGen u_clkGen (
		.CLK   (CLK),
		.RST_N (RST_N)
	);

	cacheTop u_cacheTop (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cpuReq    (cpuReq),
		.CBUS_DO   (CBUS_DO),
		.CBUS_BUSY (CBUS_BUSY),
		.memReq    (memReq),
		.IBUS_DI   (IBUS_DI),
		.IBUS_WAIT (IBUS_WAIT)
	);

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// model word index is address bits 11:2
	function automatic logic [31:0] patternFor(input logic [31:0] addr);
		logic [9:0] i;
		i = addr[11:2];
		return {6'h2A, i, 6'h15, ~i};
	endfunction

	function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] nw,
			input logic [3:0] be);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				r[b*8 +: 8] = nw[b*8 +: 8];
		end
		return r;
	endfunction

	// fills run from the word after the requested one and wrap
	function automatic memReqT expectedXfer(input stepT s, input int k);
		memReqT r;
		logic [1:0] w;
		w = s.addr[3:2] + 2'(k + 1);
		r.req = 1'b1;
		r.we = s.op == tWrite;
		r.lock = s.expCount == 4;
		r.be = r.lock ? 4'hF : s.be;
		r.addr = r.lock ? {s.addr[31:4], w, 2'b00} : s.addr;
		r.wdata = s.data;
		return r;
	endfunction

	task automatic stopRun();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkCcr(input string name, input ccrT got, input ccrT exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkMemReq(input string name, input memReqT got, input memReqT exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic addStep(input stepOpE op, input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] be, input logic [31:0] expWord, input int expCount);
		stepT s;
		s = '{op, addr, data, be, expWord, expCount};
		steps.push_back(s);
	endtask

	task automatic buildTable();
		logic [31:0] merged;
		merged = mergeBytes(patternFor(32'h44), 32'hDEADBEEF, 4'b0110);
		addStep(tCcrRead, `CCR_ADDR, 32'h0, LANE1, 32'h0, 0);
		// CE clear, every read goes to memory
		addStep(tRead, 32'h0000_0100, 32'h0, 4'hF, patternFor(32'h100), 1);
		addStep(tRead, 32'h2000_0204, 32'h0, 4'hF, patternFor(32'h204), 1);
		addStep(tRead, 32'h0000_0100, 32'h0, 4'hF, patternFor(32'h100), 1);
		addStep(tCcrWrite, `CCR_ADDR, 32'h0000_0100, LANE1, 32'h0, 0);
		addStep(tCcrRead, `CCR_ADDR, 32'h0, LANE1, {4{8'h01}}, 0);
		// miss fill of set 4, then hits
		addStep(tRead, 32'h0000_0048, 32'h0, 4'hF, patternFor(32'h48), 4);
		addStep(tRead, 32'h0000_0040, 32'h0, 4'hF, patternFor(32'h40), 0);
		addStep(tRead, 32'h0000_004C, 32'h0, 4'hF, patternFor(32'h4C), 0);
		addStep(tWrite, 32'h0000_0044, 32'hDEADBEEF, 4'b0110, 32'h0, 1);
		addStep(tRead, 32'h0000_0044, 32'h0, 4'hF, merged, 0);
		addStep(tRead, 32'h2000_0044, 32'h0, 4'hF, merged, 1);
		// four lines of set 8, first one reused
		addStep(tRead, 32'h0000_0080, 32'h0, 4'hF, patternFor(32'h80), 4);
		addStep(tRead, 32'h0000_0480, 32'h0, 4'hF, patternFor(32'h480), 4);
		addStep(tRead, 32'h0000_0880, 32'h0, 4'hF, patternFor(32'h880), 4);
		addStep(tRead, 32'h0000_0C80, 32'h0, 4'hF, patternFor(32'hC80), 4);
		addStep(tRead, 32'h0000_0080, 32'h0, 4'hF, patternFor(32'h80), 0);
		addStep(tRead, 32'h0000_1080, 32'h0, 4'hF, patternFor(32'h1080), 4);
		addStep(tRead, 32'h0000_0080, 32'h0, 4'hF, patternFor(32'h80), 0);
		addStep(tRead, 32'h0000_0480, 32'h0, 4'hF, patternFor(32'h480), 4);
		// purge drops every line
		addStep(tCcrWrite, `CCR_ADDR, 32'h0000_1100, LANE1, 32'h0, 0);
		addStep(tCcrRead, `CCR_ADDR, 32'h0, LANE1, {4{8'h01}}, 0);
		addStep(tRead, 32'h0000_0040, 32'h0, 4'hF, patternFor(32'h40), 4);
	endtask

	task automatic waitNotBusy(output logic [31:0] data, output int busyCycles);
		int cycles;
		cycles = 0;
		#1;
		while (CBUS_BUSY) begin
			if (cycles >= TIMEOUT) begin
				$display("cache kept BUSY high for %0d cycles", TIMEOUT);
				stopRun();
			end
			@(negedge CLK);
			#1;
			cycles++;
		end
		data = CBUS_DO;
		busyCycles = cycles;
	endtask

	task automatic runStep(input stepT s, input int n);
		int base;
		int busyCycles;
		logic [31:0] got;
		@(negedge CLK);
		base = xferCount;
		cpuReq = '{req: 1'b1, wr: s.op == tWrite || s.op == tCcrWrite, be: s.be,
			addr: s.addr, wdata: s.data};
		waitNotBusy(got, busyCycles);
		@(negedge CLK);
		cpuReq.req = 1'b0;
		// hits and CCR accesses finish in the request cycle
		if (s.expCount == 0)
			checkCount($sformatf("step %0d CBUS_BUSY cycles", n), busyCycles, 0);
		if (s.op == tRead)
			checkWord($sformatf("step %0d CBUS_DO", n), got, s.expWord);
		if (s.op == tCcrRead) begin
			checkCcr($sformatf("step %0d CCR", n), ccrT'(got[15:8]), ccrT'(s.expWord[15:8]));
			checkWord($sformatf("step %0d CBUS_DO", n), got, s.expWord);
		end
		checkCount($sformatf("step %0d transfer count", n), xferCount - base, s.expCount);
		for (int k = 0; k < s.expCount; k++) begin
			checkMemReq($sformatf("step %0d memReq beat %0d", n, k), xferLog[base + k],
				expectedXfer(s, k));
		end
	endtask

	// one beat at a time, 0 to 3 wait cycles each
	always @(negedge CLK) begin
		if (completing) begin
			if (beatReq.we)
				mem[beatReq.addr[11:2]] = mergeBytes(mem[beatReq.addr[11:2]], beatReq.wdata,
					beatReq.be);
			xferLog.push_back(beatReq);
			xferCount++;
			completing = 1'b0;
			beatActive = 1'b0;
		end
		if (memReq.req === 1'b1) begin
			if (!beatActive) begin
				beatActive = 1'b1;
				waitLeft = 0;
				repeat (2) begin
					lfsr = lfsrStep(lfsr);
					waitLeft = waitLeft * 2 + lfsr[0];
				end
			end
			if (waitLeft > 0) begin
				IBUS_WAIT = 1'b1;
				waitLeft--;
			end
			else begin
				IBUS_WAIT = 1'b0;
				IBUS_DI = mem[memReq.addr[11:2]];
				beatReq = memReq;
				completing = 1'b1;
			end
		end
		else begin
			IBUS_WAIT = 1'b0;
		end
	end

	// bound protocol assertions end the run at their first failure
	always @(negedge CLK) begin
		if (u_cacheTop.u_cacheChk.failCount != 0) begin
			$display("a cache protocol assertion failed");
			stopRun();
		end
	end

	initial begin
		int cycles;
		cpuReq = '0;
		IBUS_DI = '0;
		IBUS_WAIT = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = patternFor({20'h0, i[9:0], 2'b00});
		end
		buildTable();
		cycles = 0;
		while (RST_N !== 1'b1) begin
			if (cycles >= 20) begin
				$display("reset was never released");
				stopRun();
			end
			@(negedge CLK);
			cycles++;
		end
		#1;
		if (CBUS_BUSY !== 1'b0 || memReq.req !== 1'b0) begin
			$display("BUSY or IBUS request active right after reset");
			stopRun();
		end
		for (int n = 0; n < steps.size(); n++) begin
			runStep(steps[n], n);
		end
		if (u_cacheTop.u_cacheChk.failCount != 0) begin
			$display("a cache protocol assertion failed");
			stopRun();
		end
		else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* verif/cache_chk.sv */
module cacheChk import cachePkg::*; (
	input logic   CLK,
	input logic   RST_N,
	input cpuReqT cpuReq,
	input memReqT memReq,
	input logic   CBUS_BUSY,
	input logic   IBUS_WAIT
);

	timeunit 1ns;
	timeprecision 100ps;

	// number of assertion failures so far
	int failCount = 0;

	lockHasReq: assert property (@(posedge CLK) disable iff (!RST_N)
		memReq.lock |-> memReq.req)
		else begin
			$error("IBUS lock high without an IBUS request");
			failCount++;
		end

	// a stalled beat keeps every request field
	reqHeldInWait: assert property (@(posedge CLK) disable iff (!RST_N)
		(memReq.req && IBUS_WAIT) |=> $stable(memReq))
		else begin
			$error("IBUS request changed while wait was high");
			failCount++;
		end

	busyHasReq: assert property (@(posedge CLK) disable iff (!RST_N)
		CBUS_BUSY |-> cpuReq.req)
		else begin
			$error("CBUS BUSY high without a CPU request");
			failCount++;
		end

	noReqAfterReset: assert property (@(posedge CLK)
		$rose(RST_N) |-> !memReq.req)
		else begin
			$error("IBUS request in the first cycle after reset");
			failCount++;
		end

endmodule

bind cacheTop cacheChk u_cacheChk (.*);

/* verif/clkGen.sv */
module clkGen #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic RST_N
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		RST_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
	end

endmodule
